// ==== filelist.f ====
+incdir+rtl
rtl/rtc_map_pkg.sv
rtl/rtc_key_pkg.sv
rtl/key_decode.sv
rtl/field_cursor.sv
rtl/field_bank.sv
rtl/write_port.sv
rtl/rtc_field_editor.sv
bench/tb_rtc_field_editor.sv

// ==== Bender.yml ====
package:
  name: rtc_field_editor

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rtc_map_pkg.sv
      - rtl/rtc_key_pkg.sv
      - rtl/key_decode.sv
      - rtl/field_cursor.sv
      - rtl/field_bank.sv
      - rtl/write_port.sv
      - rtl/rtc_field_editor.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/tb_rtc_field_editor.sv

// ==== bench/tb_rtc_field_editor.sv ====
`timescale 1ns/1ps
`include "rtc_edit_params.svh"

module tb_rtc_field_editor;

  import rtc_map_pkg::*;
  import rtc_key_pkg::*;

  localparam int WAIT_LIMIT = 64;

  logic clk;
  logic reset;
  logic edit_time;
  logic edit_timer;
  logic inc;
  logic dec;
  logic left;
  logic right;
  logic load;
  logic [`RTC_BYTE_W-1:0] snap [1:`RTC_NUM_FIELDS-1];
  logic [`RTC_BYTE_W-1:0] wr_addr;
  logic [`RTC_BYTE_W-1:0] wr_data;
  logic [`RTC_BYTE_W-1:0] mode_out;
  logic [`RTC_BYTE_W-1:0] sec_out;
  logic [`RTC_BYTE_W-1:0] min_out;
  logic [`RTC_BYTE_W-1:0] hour_out;
  logic [`RTC_BYTE_W-1:0] date_out;
  logic [`RTC_BYTE_W-1:0] month_out;
  logic [`RTC_BYTE_W-1:0] year_out;
  logic [`RTC_BYTE_W-1:0] weekday_out;
  logic [`RTC_BYTE_W-1:0] week_out;
  logic [`RTC_BYTE_W-1:0] timer_sec_out;
  logic [`RTC_BYTE_W-1:0] timer_min_out;
  logic [`RTC_BYTE_W-1:0] timer_hour_out;

  integer seed = 32'he55f2d47;
  int     errors = 0;
  int     checks = 0;
  int     m_cursor;  // model cursor
  bit     m_time;
  bit     m_timer;
  bit     m_load;
  logic [`RTC_BYTE_W-1:0] m_fields [`RTC_NUM_FIELDS];
  bit     check_pending;
  string  check_name;

  rtc_field_editor i_dut (
    .clk (clk), .reset (reset), .edit_time (edit_time), .edit_timer (edit_timer),
    .inc (inc), .dec (dec), .left (left), .right (right), .load (load),
    .rtc_sec (snap[1]), .rtc_min (snap[2]), .rtc_hour (snap[3]), .rtc_date (snap[4]),
    .rtc_month (snap[5]), .rtc_year (snap[6]), .rtc_weekday (snap[7]), .rtc_week (snap[8]),
    .rtc_timer_sec (snap[9]), .rtc_timer_min (snap[10]), .rtc_timer_hour (snap[11]),
    .wr_addr (wr_addr), .wr_data (wr_data), .mode_out (mode_out), .sec_out (sec_out),
    .min_out (min_out), .hour_out (hour_out), .date_out (date_out), .month_out (month_out),
    .year_out (year_out), .weekday_out (weekday_out), .week_out (week_out),
    .timer_sec_out (timer_sec_out), .timer_min_out (timer_min_out),
    .timer_hour_out (timer_hour_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [`RTC_BYTE_W-1:0] dut_field(input int idx);
    case (idx)
      0: return mode_out;
      1: return sec_out;
      2: return min_out;
      3: return hour_out;
      4: return date_out;
      5: return month_out;
      6: return year_out;
      7: return weekday_out;
      8: return week_out;
      9: return timer_sec_out;
      10: return timer_min_out;
      default: return timer_hour_out;
    endcase
  endfunction

  function automatic logic [`RTC_BYTE_W-1:0] expected_addr(input int idx);
    if (idx == 0) return 8'h00;
    else if (idx <= `RTC_TIME_LAST) return 8'(8'h20 + idx);  // clock page
    else return 8'(8'h41 + (idx - `RTC_TIMER_FIRST));  // timer page
  endfunction

  // ring entry and return to zero on a mode change
  function automatic void model_mode(input bit t, input bit tm);
    m_time = t;
    m_timer = tm;
    if (t && !tm && m_cursor > `RTC_TIME_LAST) m_cursor = 0;
    else if (!t && tm && m_cursor < `RTC_TIMER_FIRST) m_cursor = `RTC_TIMER_FIRST;
    else if (!t && !tm) m_cursor = 0;
  endfunction

  function automatic void model_apply(input key_cmd_t k);
    int first_idx;
    int last_idx;
    if (m_time == m_timer) return;  // idle or both modes
    first_idx = m_time ? 0 : `RTC_TIMER_FIRST;
    last_idx = m_time ? `RTC_TIME_LAST : `RTC_TIMER_LAST;
    case (k)
      KEY_RIGHT: m_cursor = (m_cursor == last_idx) ? first_idx : m_cursor + 1;
      KEY_LEFT: m_cursor = (m_cursor == first_idx) ? last_idx : m_cursor - 1;
      KEY_INC, KEY_DEC: begin
        if (m_load) return;  // step lost during load
        if (m_cursor == 0) m_fields[0] = (k == KEY_INC) ? `RTC_MODE_12H : `RTC_MODE_24H;
        else if (k == KEY_INC) m_fields[m_cursor] = m_fields[m_cursor] + 8'd1;
        else m_fields[m_cursor] = m_fields[m_cursor] - 8'd1;
      end
      default: ;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [`RTC_BYTE_W-1:0] expected,
                             input logic [`RTC_BYTE_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s expected 0x%02h actual 0x%02h", name, expected, actual);
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("checks %0d errors %0d", checks, errors);
    $display("Regression failed");
    $finish;
  endtask

  task automatic wait_falls(input int n, input string why);
    int count;
    count = 0;
    while (count < n) begin
      @(negedge clk);
      count++;
      if (count > WAIT_LIMIT) abort_run(why);
    end
  endtask

  task automatic request_check(input string name);
    int guard;
    guard = 0;
    check_name = name;
    check_pending <= 1'b1;  // picked up on the next fall
    do begin
      @(negedge clk);
      guard++;
      if (guard > WAIT_LIMIT) abort_run("compare process did not respond");
    end while (check_pending);
  endtask

  // all outputs against the model, between rising edges
  always @(negedge clk) begin
    if (check_pending) begin
      for (int i = 0; i < `RTC_NUM_FIELDS; i++) begin
        check_value($sformatf("%s field %0d", check_name, i), m_fields[i], dut_field(i));
      end
      check_value({check_name, " wr_addr"}, expected_addr(m_cursor), wr_addr);
      check_value({check_name, " wr_data"}, m_fields[m_cursor], wr_data);
      check_pending <= 1'b0;
    end
  end

  task automatic drive_keys(input key_cmd_t k);
    inc = (k == KEY_INC);
    dec = (k == KEY_DEC);
    left = (k == KEY_LEFT);
    right = (k == KEY_RIGHT);
  endtask

  task automatic press(input key_cmd_t k, input string name);
    drive_keys(k);
    model_apply(k);
    wait_falls(1, "key was not sampled");
    drive_keys(KEY_NONE);
    wait_falls(3, "pipeline did not settle");
    request_check(name);
  endtask

  task automatic press_chord(input logic [3:0] keys, input string name);
    {inc, dec, left, right} = keys;
    wait_falls(1, "key was not sampled");
    drive_keys(KEY_NONE);
    wait_falls(3, "pipeline did not settle");
    request_check(name);
  endtask

  task automatic set_mode(input bit t, input bit tm, input string name);
    edit_time = t;
    edit_timer = tm;
    model_mode(t, tm);
    wait_falls(4, "pipeline did not settle");
    request_check(name);
  endtask

  task automatic load_snapshot(input string name);
    for (int i = 1; i < `RTC_NUM_FIELDS; i++) begin
      snap[i] = 8'($random(seed));
      m_fields[i] = snap[i];
    end
    load = 1'b1;
    m_load = 1'b1;
    wait_falls(2, "load was not sampled");
    request_check(name);
    press(KEY_INC, {name, " inc"});
    press(KEY_DEC, {name, " dec"});
    load = 1'b0;
    m_load = 1'b0;
    wait_falls(1, "load did not drop");
  endtask

  initial begin
    key_cmd_t k;
    reset = 1'b1;
    edit_time = 1'b0;
    edit_timer = 1'b0;
    load = 1'b0;
    drive_keys(KEY_NONE);
    check_pending = 1'b0;
    m_cursor = 0;
    m_time = 1'b0;
    m_timer = 1'b0;
    m_load = 1'b0;
    for (int i = 0; i < `RTC_NUM_FIELDS; i++) m_fields[i] = '0;
    for (int i = 1; i < `RTC_NUM_FIELDS; i++) snap[i] = '0;
    wait_falls(10, "reset did not finish");
    reset = 1'b0;
    wait_falls(1, "reset did not release");
    request_check("reset");

    set_mode(1'b1, 1'b0, "time entry");
    load_snapshot("load");
    for (int i = 0; i < 40; i++) begin
      k = key_cmd_t'(({$random(seed)} % 4) + 1);
      press(k, "time ring");
    end

    while (m_cursor != 0) press(KEY_LEFT, "mode seek");
    press(KEY_INC, "mode inc");
    check_value("mode inc byte", 8'h10, mode_out);
    press(KEY_DEC, "mode dec");
    check_value("mode dec byte", 8'h00, mode_out);

    set_mode(1'b0, 1'b1, "timer entry");
    check_value("timer entry addr", 8'h41, wr_addr);
    while (m_cursor != `RTC_TIMER_LAST) press(KEY_RIGHT, "timer seek");
    press(KEY_RIGHT, "timer wrap");
    check_value("timer wrap addr", 8'h41, wr_addr);
    for (int i = 0; i < 12; i++) begin
      k = $random(seed) & 1 ? KEY_INC : KEY_DEC;
      press(k, "timer step");
    end
    set_mode(1'b0, 1'b0, "idle");
    check_value("idle addr", 8'h00, wr_addr);

    set_mode(1'b1, 1'b0, "time again");
    press_chord(4'b1001, "chord inc right");
    press_chord(4'b0110, "chord dec left");
    set_mode(1'b1, 1'b1, "both modes");
    press(KEY_INC, "both modes inc");
    press(KEY_RIGHT, "both modes right");
    for (int i = 0; i < 10; i++) begin
      set_mode(1'($random(seed)), 1'($random(seed)), "random mode");
      press(key_cmd_t'(({$random(seed)} % 4) + 1), "random mode key");
    end

    set_mode(1'b1, 1'b0, "back to time");
    while (m_cursor != 1) press(KEY_RIGHT, "seconds seek");
    drive_keys(KEY_INC);
    for (int i = 0; i < 3; i++) model_apply(KEY_INC);
    wait_falls(3, "held key was not sampled");
    drive_keys(KEY_NONE);
    wait_falls(3, "pipeline did not settle");
    request_check("back to back inc");

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== rtl/rtc_field_editor.sv ====
`timescale 1ns/1ps
`include "rtc_edit_params.svh"

module rtc_field_editor (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   edit_time,
  input  logic                   edit_timer,
  input  logic                   inc,
  input  logic                   dec,
  input  logic                   left,
  input  logic                   right,
  input  logic                   load,
  input  logic [`RTC_BYTE_W-1:0] rtc_sec,
  input  logic [`RTC_BYTE_W-1:0] rtc_min,
  input  logic [`RTC_BYTE_W-1:0] rtc_hour,
  input  logic [`RTC_BYTE_W-1:0] rtc_date,
  input  logic [`RTC_BYTE_W-1:0] rtc_month,
  input  logic [`RTC_BYTE_W-1:0] rtc_year,
  input  logic [`RTC_BYTE_W-1:0] rtc_weekday,
  input  logic [`RTC_BYTE_W-1:0] rtc_week,
  input  logic [`RTC_BYTE_W-1:0] rtc_timer_sec,
  input  logic [`RTC_BYTE_W-1:0] rtc_timer_min,
  input  logic [`RTC_BYTE_W-1:0] rtc_timer_hour,
  output logic [`RTC_BYTE_W-1:0] wr_addr,
  output logic [`RTC_BYTE_W-1:0] wr_data,
  output logic [`RTC_BYTE_W-1:0] mode_out,
  output logic [`RTC_BYTE_W-1:0] sec_out,
  output logic [`RTC_BYTE_W-1:0] min_out,
  output logic [`RTC_BYTE_W-1:0] hour_out,
  output logic [`RTC_BYTE_W-1:0] date_out,
  output logic [`RTC_BYTE_W-1:0] month_out,
  output logic [`RTC_BYTE_W-1:0] year_out,
  output logic [`RTC_BYTE_W-1:0] weekday_out,
  output logic [`RTC_BYTE_W-1:0] week_out,
  output logic [`RTC_BYTE_W-1:0] timer_sec_out,
  output logic [`RTC_BYTE_W-1:0] timer_min_out,
  output logic [`RTC_BYTE_W-1:0] timer_hour_out
);

  import rtc_map_pkg::*;
  import rtc_key_pkg::*;

  key_cmd_t               cmd;
  key_cmd_t               step;
  field_idx_t             sel;
  field_idx_t             sel_q;
  logic [`RTC_BYTE_W-1:0] sel_value;

  key_decode i_key_decode (
    .clk   (clk),
    .reset (reset),
    .inc   (inc),
    .dec   (dec),
    .left  (left),
    .right (right),
    .cmd   (cmd)
  );

  field_cursor i_field_cursor (
    .clk        (clk),
    .reset      (reset),
    .edit_time  (edit_time),
    .edit_timer (edit_timer),
    .cmd        (cmd),
    .sel        (sel),
    .step       (step)
  );

  field_bank i_field_bank (
    .clk            (clk),
    .reset          (reset),
    .load           (load),
    .sel            (sel),
    .step           (step),
    .rtc_sec        (rtc_sec),
    .rtc_min        (rtc_min),
    .rtc_hour       (rtc_hour),
    .rtc_date       (rtc_date),
    .rtc_month      (rtc_month),
    .rtc_year       (rtc_year),
    .rtc_weekday    (rtc_weekday),
    .rtc_week       (rtc_week),
    .rtc_timer_sec  (rtc_timer_sec),
    .rtc_timer_min  (rtc_timer_min),
    .rtc_timer_hour (rtc_timer_hour),
    .mode_out       (mode_out),
    .sec_out        (sec_out),
    .min_out        (min_out),
    .hour_out       (hour_out),
    .date_out       (date_out),
    .month_out      (month_out),
    .year_out       (year_out),
    .weekday_out    (weekday_out),
    .week_out       (week_out),
    .timer_sec_out  (timer_sec_out),
    .timer_min_out  (timer_min_out),
    .timer_hour_out (timer_hour_out),
    .sel_q          (sel_q),
    .sel_value      (sel_value)
  );

  write_port i_write_port (
    .clk       (clk),
    .reset     (reset),
    .sel_q     (sel_q),
    .sel_value (sel_value),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

endmodule

// ==== rtl/write_port.sv ====
`timescale 1ns/1ps
`include "rtc_edit_params.svh"

module write_port (
  input  logic                    clk,
  input  logic                    reset,
  input  rtc_map_pkg::field_idx_t sel_q,
  input  logic [`RTC_BYTE_W-1:0]  sel_value,
  output logic [`RTC_BYTE_W-1:0]  wr_addr,
  output logic [`RTC_BYTE_W-1:0]  wr_data
);

  import rtc_map_pkg::*;

  logic [`RTC_BYTE_W-1:0] addr_next;

  assign addr_next = field_addr[sel_q];  // register map lookup

  // address and data change on the same edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_addr <= '0;
      wr_data <= '0;
    end else begin
      wr_addr <= addr_next;
      wr_data <= sel_value;
    end
  end

endmodule

// ==== rtl/field_bank.sv ====
`timescale 1ns/1ps
`include "rtc_edit_params.svh"

module field_bank (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    load,
  input  rtc_map_pkg::field_idx_t sel,
  input  rtc_key_pkg::key_cmd_t   step,
  input  logic [`RTC_BYTE_W-1:0]  rtc_sec,
  input  logic [`RTC_BYTE_W-1:0]  rtc_min,
  input  logic [`RTC_BYTE_W-1:0]  rtc_hour,
  input  logic [`RTC_BYTE_W-1:0]  rtc_date,
  input  logic [`RTC_BYTE_W-1:0]  rtc_month,
  input  logic [`RTC_BYTE_W-1:0]  rtc_year,
  input  logic [`RTC_BYTE_W-1:0]  rtc_weekday,
  input  logic [`RTC_BYTE_W-1:0]  rtc_week,
  input  logic [`RTC_BYTE_W-1:0]  rtc_timer_sec,
  input  logic [`RTC_BYTE_W-1:0]  rtc_timer_min,
  input  logic [`RTC_BYTE_W-1:0]  rtc_timer_hour,
  output logic [`RTC_BYTE_W-1:0]  mode_out,
  output logic [`RTC_BYTE_W-1:0]  sec_out,
  output logic [`RTC_BYTE_W-1:0]  min_out,
  output logic [`RTC_BYTE_W-1:0]  hour_out,
  output logic [`RTC_BYTE_W-1:0]  date_out,
  output logic [`RTC_BYTE_W-1:0]  month_out,
  output logic [`RTC_BYTE_W-1:0]  year_out,
  output logic [`RTC_BYTE_W-1:0]  weekday_out,
  output logic [`RTC_BYTE_W-1:0]  week_out,
  output logic [`RTC_BYTE_W-1:0]  timer_sec_out,
  output logic [`RTC_BYTE_W-1:0]  timer_min_out,
  output logic [`RTC_BYTE_W-1:0]  timer_hour_out,
  output rtc_map_pkg::field_idx_t sel_q,
  output logic [`RTC_BYTE_W-1:0]  sel_value
);

  import rtc_map_pkg::*;
  import rtc_key_pkg::*;

  logic [`RTC_BYTE_W-1:0] field_q [`RTC_NUM_FIELDS];
  logic [`RTC_BYTE_W-1:0] snap    [1:`RTC_NUM_FIELDS-1];  // no snapshot for mode

  assign snap[1]  = rtc_sec;
  assign snap[2]  = rtc_min;
  assign snap[3]  = rtc_hour;
  assign snap[4]  = rtc_date;
  assign snap[5]  = rtc_month;
  assign snap[6]  = rtc_year;
  assign snap[7]  = rtc_weekday;
  assign snap[8]  = rtc_week;
  assign snap[9]  = rtc_timer_sec;
  assign snap[10] = rtc_timer_min;
  assign snap[11] = rtc_timer_hour;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `RTC_NUM_FIELDS; i++) field_q[i] <= '0;
      sel_q <= FLD_MODE;
    end else begin
      sel_q <= sel;
      if (load) begin
        for (int i = 1; i < `RTC_NUM_FIELDS; i++) field_q[i] <= snap[i];  // steps dropped
      end else if (sel == FLD_MODE) begin
        if (step == KEY_INC) field_q[FLD_MODE] <= `RTC_MODE_12H;
        else if (step == KEY_DEC) field_q[FLD_MODE] <= `RTC_MODE_24H;
      end else if (step == KEY_INC) begin
        field_q[sel] <= field_q[sel] + 1'b1;  // 8 bit wrap
      end else if (step == KEY_DEC) begin
        field_q[sel] <= field_q[sel] - 1'b1;
      end
    end
  end

  assign sel_value = field_q[sel_q];  // value after the step

  assign mode_out       = field_q[0];
  assign sec_out        = field_q[1];
  assign min_out        = field_q[2];
  assign hour_out       = field_q[3];
  assign date_out       = field_q[4];
  assign month_out      = field_q[5];
  assign year_out       = field_q[6];
  assign weekday_out    = field_q[7];
  assign week_out       = field_q[8];
  assign timer_sec_out  = field_q[9];
  assign timer_min_out  = field_q[10];
  assign timer_hour_out = field_q[11];

  a_mode_byte: assert property (@(posedge clk) disable iff (reset)
    field_q[FLD_MODE] inside {`RTC_MODE_12H, `RTC_MODE_24H});

endmodule

// ==== rtl/field_cursor.sv ====
`timescale 1ns/1ps
`include "rtc_edit_params.svh"

module field_cursor (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    edit_time,
  input  logic                    edit_timer,
  input  rtc_key_pkg::key_cmd_t   cmd,
  output rtc_map_pkg::field_idx_t sel,
  output rtc_key_pkg::key_cmd_t   step
);

  import rtc_map_pkg::*;
  import rtc_key_pkg::*;

  localparam field_idx_t TIME_LAST   = field_idx_t'(`RTC_TIME_LAST);
  localparam field_idx_t TIMER_FIRST = field_idx_t'(`RTC_TIMER_FIRST);
  localparam field_idx_t TIMER_LAST  = field_idx_t'(`RTC_TIMER_LAST);

  logic       time_q;
  logic       timer_q;
  logic       in_time;
  logic       in_timer;
  field_idx_t ring_sel;
  field_idx_t sel_next;
  key_cmd_t   step_next;

  assign in_time  = time_q && !timer_q;
  assign in_timer = timer_q && !time_q;

  always_comb begin
    ring_sel  = sel;
    sel_next  = sel;  // both modes high holds
    step_next = KEY_NONE;
    if (in_time) begin
      if (sel > TIME_LAST) ring_sel = FLD_MODE;  // coming from timer ring
      sel_next = ring_sel;
      if (cmd == KEY_RIGHT) begin
        sel_next = (ring_sel == TIME_LAST) ? FLD_MODE : ring_sel + 1'b1;
      end else if (cmd == KEY_LEFT) begin
        sel_next = (ring_sel == FLD_MODE) ? TIME_LAST : ring_sel - 1'b1;
      end
    end else if (in_timer) begin
      if (sel < TIMER_FIRST) ring_sel = TIMER_FIRST;
      sel_next = ring_sel;
      if (cmd == KEY_RIGHT) begin
        sel_next = (ring_sel == TIMER_LAST) ? TIMER_FIRST : ring_sel + 1'b1;
      end else if (cmd == KEY_LEFT) begin
        sel_next = (ring_sel == TIMER_FIRST) ? TIMER_LAST : ring_sel - 1'b1;
      end
    end else if (!time_q && !timer_q) begin
      sel_next = FLD_MODE;
    end
    if ((in_time || in_timer) && (cmd == KEY_INC || cmd == KEY_DEC)) begin
      step_next = cmd;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      time_q  <= 1'b0;
      timer_q <= 1'b0;
      sel     <= FLD_MODE;
      step    <= KEY_NONE;
    end else begin
      time_q  <= edit_time;  // lines up with cmd from key_decode
      timer_q <= edit_timer;
      sel     <= sel_next;
      step    <= step_next;
    end
  end

  a_sel_range: assert property (@(posedge clk) disable iff (reset) sel <= TIMER_LAST);

  a_time_ring: assert property (@(posedge clk) disable iff (reset)
    (edit_time && !edit_timer) |-> ##2 (sel <= TIME_LAST));

endmodule

// ==== rtl/key_decode.sv ====
`timescale 1ns/1ps
`include "rtc_edit_params.svh"

module key_decode (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  inc,
  input  logic                  dec,
  input  logic                  left,
  input  logic                  right,
  output rtc_key_pkg::key_cmd_t cmd
);

  import rtc_key_pkg::*;

  logic [3:0] keys;
  key_cmd_t   cmd_next;

  assign keys = {inc, dec, left, right};

  always_comb begin
    case (keys)
      4'b1000: cmd_next = KEY_INC;
      4'b0100: cmd_next = KEY_DEC;
      4'b0010: cmd_next = KEY_LEFT;
      4'b0001: cmd_next = KEY_RIGHT;
      default: cmd_next = KEY_NONE;  // idle or chord
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cmd <= KEY_NONE;
    end else begin
      cmd <= cmd_next;
    end
  end

  a_chord_ignored: assert property (@(posedge clk) disable iff (reset)
    !$onehot(keys) |=> cmd == KEY_NONE);

endmodule

// ==== rtl/rtc_key_pkg.sv ====
package rtc_key_pkg;

  // one operator command per cycle
  typedef enum logic [2:0] {
    KEY_NONE  = 3'd0,
    KEY_INC   = 3'd1,
    KEY_DEC   = 3'd2,
    KEY_LEFT  = 3'd3,
    KEY_RIGHT = 3'd4
  } key_cmd_t;

endpackage

// ==== rtl/rtc_map_pkg.sv ====
`include "rtc_edit_params.svh"

package rtc_map_pkg;

  // 0 mode, 1..8 clock fields, 9..11 timer fields
  typedef logic [3:0] field_idx_t;

  localparam field_idx_t FLD_MODE = 4'd0;

  // bus address per field index
  localparam logic [`RTC_BYTE_W-1:0] field_addr [`RTC_NUM_FIELDS] = '{
    8'h00,  // mode 12/24
    8'h21,  // seconds
    8'h22,  // minutes
    8'h23,  // hours
    8'h24,  // date
    8'h25,  // month
    8'h26,  // year
    8'h27,  // weekday
    8'h28,  // week number
    8'h41,  // timer seconds
    8'h42,  // timer minutes
    8'h43   // timer hours
  };

endpackage

// ==== rtl/rtc_edit_params.svh ====
`ifndef RTC_EDIT_PARAMS_SVH
`define RTC_EDIT_PARAMS_SVH

// field and bus address width
`define RTC_BYTE_W 8

// mode byte plus eight clock fields plus three timer fields
`define RTC_NUM_FIELDS 12

// last index of the time ring, which starts at 0
`define RTC_TIME_LAST 8

// timer ring bounds
`define RTC_TIMER_FIRST 9
`define RTC_TIMER_LAST 11

// mode byte values
`define RTC_MODE_12H 8'h10
`define RTC_MODE_24H 8'h00

`endif
